/* mesh_pll_params.svh */
`ifndef MESH_PLL_PARAMS_SVH
`define MESH_PLL_PARAMS_SVH

// widths
`define MESH_PHASE_W        16      // nco phase accumulator
`define MESH_PDET_W         5       // signed phase error
`define MESH_WEIGHT_W       4
`define MESH_GAIN_W         4
`define MESH_CTRL_W         16      // signed nco correction

// 336/65536 per cycle gives 21 reference periods in 4096 cycles
`define MESH_REF_INC        336

// nodes run at 8x the reference when on centre
`define MESH_NODE_BASE_INC  2688

// increment lost per unit of ring-length offset
`define MESH_OFFSET_SCALE   8

// loop filter scaling, right shifts
`define MESH_KP_SHIFT       2
`define MESH_KI_SHIFT       4

`endif

/* mesh_pll_pkg.sv */
`include "mesh_pll_params.svh"

package mesh_pll_pkg;

    typedef logic [`MESH_PHASE_W-1:0] phase_t;
    typedef logic signed [`MESH_PDET_W-1:0] perr_t;
    typedef logic [`MESH_WEIGHT_W-1:0] weight_t;
    typedef logic [`MESH_GAIN_W-1:0] gain_t;
    typedef logic signed [`MESH_CTRL_W-1:0] ctrl_t;

    typedef struct packed {
        logic  enable;
        logic  network;     // 0 pll, 1 network
        logic  uni_dir;     // 1 unidirectional weights
        gain_t kp;
        gain_t ki;
    } mesh_cfg_t;

    typedef struct packed {
        weight_t left;
        weight_t above;
        weight_t right;
        weight_t below;
    } node_weights_t;

    // already negated by the top
    typedef struct packed {
        perr_t err_right;
        perr_t err_below;
    } nbr_err_t;

    // ring-length offsets, row-major 11 .. 33
    localparam int node_ring_offset [9] = '{0, 2, 18, 12, 10, -4, 0, 8, 0};

    // longer ring means a slower free-running node
    localparam phase_t node_center_inc [9] = '{
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[0]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[1]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[2]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[3]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[4]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[5]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[6]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[7]),
        phase_t'(`MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * node_ring_offset[8])
    };

endpackage

/* node_nco.sv */
`timescale 1ns/1ps

module node_nco (
    input  logic                 clk258_x,
    input  logic                 rst_n_i,
    input  logic                 enable_i,
    input  mesh_pll_pkg::phase_t center_inc_i,
    input  mesh_pll_pkg::ctrl_t  ctrl_i,
    output logic                 clk_o
);
    import mesh_pll_pkg::*;

    phase_t acc_q;
    phase_t step;

    // correction is two's complement, wraps into the increment
    assign step = center_inc_i + phase_t'(ctrl_i);

    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            acc_q <= '0;
        end
        else if (!enable_i)
        begin
            acc_q <= '0;    // hold at zero, output stays low
        end
        else
        begin
            acc_q <= acc_q + step;
        end
    end

    assign clk_o = acc_q[$bits(phase_t)-1];

endmodule

/* bb_phase_detector.sv */
`timescale 1ns/1ps

module bb_phase_detector (
    input  logic                clk258_x,
    input  logic                rst_n_i,
    input  logic                ref_i,
    input  logic                fb_i,
    output mesh_pll_pkg::perr_t err_o,
    output logic                err_stb_o
);
    import mesh_pll_pkg::*;

    typedef enum logic [1:0] {
        PD_IDLE,
        PD_REF_LEAD,
        PD_FB_LEAD
    } pd_state_t;

    localparam perr_t ERR_REF_LEAD = perr_t'(1);     // feedback too slow
    localparam perr_t ERR_FB_LEAD = perr_t'(-1);

    pd_state_t state_q;
    logic      ref_q;
    logic      fb_q;
    logic      ref_rise;
    logic      fb_rise;

    assign ref_rise = ref_i & ~ref_q;
    assign fb_rise = fb_i & ~fb_q;

    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            state_q <= PD_IDLE;
            ref_q <= 1'b0;
            fb_q <= 1'b0;
            err_o <= '0;
            err_stb_o <= 1'b0;
        end
        else
        begin
            ref_q <= ref_i;
            fb_q <= fb_i;
            err_stb_o <= 1'b0;
            case (state_q)
                PD_IDLE:
                begin
                    if (ref_rise && fb_rise)
                    begin
                        err_o <= '0;    // coincident edges
                        err_stb_o <= 1'b1;
                    end
                    else if (ref_rise)
                    begin
                        state_q <= PD_REF_LEAD;
                    end
                    else if (fb_rise)
                    begin
                        state_q <= PD_FB_LEAD;
                    end
                end
                PD_REF_LEAD:
                begin
                    // further ref edges are ignored until fb shows up
                    if (fb_rise)
                    begin
                        err_o <= ERR_REF_LEAD;
                        err_stb_o <= 1'b1;
                        state_q <= PD_IDLE;
                    end
                end
                PD_FB_LEAD:
                begin
                    if (ref_rise)
                    begin
                        err_o <= ERR_FB_LEAD;
                        err_stb_o <= 1'b1;
                        state_q <= PD_IDLE;
                    end
                end
                default:
                begin
                    state_q <= PD_IDLE;
                end
            endcase
        end
    end

endmodule

/* loop_filter.sv */
`timescale 1ns/1ps
`include "mesh_pll_params.svh"

module loop_filter (
    input  logic                        clk258_x,
    input  logic                        rst_n_i,
    input  mesh_pll_pkg::perr_t         err_i,
    input  logic                        err_stb_i,
    input  mesh_pll_pkg::nbr_err_t      nbr_i,
    input  mesh_pll_pkg::node_weights_t weights_i,
    input  mesh_pll_pkg::gain_t         kp_i,
    input  mesh_pll_pkg::gain_t         ki_i,
    output mesh_pll_pkg::ctrl_t         ctrl_o
);
    import mesh_pll_pkg::*;

    localparam int MIX_W = `MESH_PDET_W + `MESH_WEIGHT_W + 3;
    localparam int INT_W = `MESH_CTRL_W + `MESH_KI_SHIFT;   // keeps ki fraction bits
    localparam int SUM_W = INT_W + 2;
    localparam longint INT_MAX = (longint'(1) <<< (INT_W - 1)) - 1;
    localparam longint INT_MIN = -(longint'(1) <<< (INT_W - 1));
    localparam longint CTRL_MAX = (longint'(1) <<< (`MESH_CTRL_W - 1)) - 1;
    localparam longint CTRL_MIN = -(longint'(1) <<< (`MESH_CTRL_W - 1));

    logic signed [MIX_W-1:0]       w_own;
    logic signed [MIX_W-1:0]       w_right;
    logic signed [MIX_W-1:0]       w_below;
    logic signed [MIX_W-1:0]       mix;
    logic signed [`MESH_GAIN_W:0]  kp_s;
    logic signed [`MESH_GAIN_W:0]  ki_s;
    logic signed [SUM_W-1:0]       integ_sum;
    logic signed [SUM_W-1:0]       ctrl_sum;
    logic signed [INT_W-1:0]       integ_q;
    logic signed [INT_W-1:0]       integ_d;
    ctrl_t                         ctrl_d;

    always_comb
    begin
        w_own = MIX_W'(weights_i.left) + MIX_W'(weights_i.above);
        w_right = MIX_W'(weights_i.right);
        w_below = MIX_W'(weights_i.below);
        kp_s = {1'b0, kp_i};
        ki_s = {1'b0, ki_i};

        mix = w_own * err_i
            + w_right * $signed(nbr_i.err_right)
            + w_below * $signed(nbr_i.err_below);

        integ_sum = integ_q + ki_s * mix;
        if (integ_sum > INT_MAX)
            integ_d = INT_W'(INT_MAX);
        else if (integ_sum < INT_MIN)
            integ_d = INT_W'(INT_MIN);
        else
            integ_d = integ_sum[INT_W-1:0];

        ctrl_sum = ((kp_s * mix) >>> `MESH_KP_SHIFT) + (integ_d >>> `MESH_KI_SHIFT);
        if (ctrl_sum > CTRL_MAX)
            ctrl_d = ctrl_t'(CTRL_MAX);
        else if (ctrl_sum < CTRL_MIN)
            ctrl_d = ctrl_t'(CTRL_MIN);
        else
            ctrl_d = ctrl_sum[`MESH_CTRL_W-1:0];
    end

    // updates once per detector strobe
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            integ_q <= '0;
            ctrl_o <= '0;
        end
        else if (err_stb_i)
        begin
            integ_q <= integ_d;
            ctrl_o <= ctrl_d;
        end
    end

endmodule

/* adpll_node.sv */
`timescale 1ns/1ps

module adpll_node (
    input  logic                        clk258_x,
    input  logic                        rst_n_i,
    input  logic                        enable_i,
    input  mesh_pll_pkg::phase_t        center_inc_i,
    input  logic                        ref_i,
    input  mesh_pll_pkg::nbr_err_t      nbr_i,
    input  mesh_pll_pkg::node_weights_t weights_i,
    input  mesh_pll_pkg::gain_t         kp_i,
    input  mesh_pll_pkg::gain_t         ki_i,
    output mesh_pll_pkg::perr_t         err_o,
    output logic                        gen_o,
    output logic                        div8_o
);
    import mesh_pll_pkg::*;

    ctrl_t      ctrl;
    logic       err_stb;
    logic       gen_q;
    logic [2:0] div_cnt_q;

    bb_phase_detector pd_inst (
        .clk258_x  (clk258_x),
        .rst_n_i   (rst_n_i),
        .ref_i     (ref_i),
        .fb_i      (div8_o),    // locks gen at 8x ref
        .err_o     (err_o),
        .err_stb_o (err_stb)
    );

    loop_filter lf_inst (
        .clk258_x  (clk258_x),
        .rst_n_i   (rst_n_i),
        .err_i     (err_o),
        .err_stb_i (err_stb),
        .nbr_i     (nbr_i),
        .weights_i (weights_i),
        .kp_i      (kp_i),
        .ki_i      (ki_i),
        .ctrl_o    (ctrl)
    );

    node_nco nco_inst (
        .clk258_x     (clk258_x),
        .rst_n_i      (rst_n_i),
        .enable_i     (enable_i),
        .center_inc_i (center_inc_i),
        .ctrl_i       (ctrl),
        .clk_o        (gen_o)
    );

    // divide by 8 on gen rising edges
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i || !enable_i)
        begin
            gen_q <= 1'b0;
            div_cnt_q <= '0;
        end
        else
        begin
            gen_q <= gen_o;
            if (gen_o && !gen_q)
                div_cnt_q <= div_cnt_q + 3'd1;
        end
    end

    assign div8_o = div_cnt_q[2];

endmodule

/* mesh_config.sv */
`timescale 1ns/1ps

module mesh_config (
    input  logic                              clk258_x,
    input  logic                              rst_n_i,
    input  logic                              cfg_load_i,
    input  mesh_pll_pkg::mesh_cfg_t           cfg_i,
    input  logic                              ref_clk_i,
    input  logic [8:0]                        div8_i,
    output mesh_pll_pkg::mesh_cfg_t           cfg_o,
    output mesh_pll_pkg::node_weights_t [8:0] weights_o,
    output logic [8:0]                        node_ref_o
);
    import mesh_pll_pkg::*;

    // {left, above, right, below} per node, row-major
    localparam node_weights_t UNI_W [9] = '{
        '{4'd4, 4'd0, 4'd0, 4'd0},
        '{4'd4, 4'd0, 4'd0, 4'd0},
        '{4'd4, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd4, 4'd0, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0},
        '{4'd0, 4'd4, 4'd0, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0}
    };

    localparam node_weights_t BI_W [9] = '{
        '{4'd2, 4'd0, 4'd1, 4'd1},
        '{4'd1, 4'd0, 4'd1, 4'd1},
        '{4'd2, 4'd0, 4'd0, 4'd2},
        '{4'd0, 4'd1, 4'd1, 4'd1},
        '{4'd1, 4'd1, 4'd1, 4'd1},
        '{4'd1, 4'd1, 4'd0, 4'd1},
        '{4'd0, 4'd2, 4'd2, 4'd0},
        '{4'd1, 4'd2, 4'd1, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0}
    };

    // network mode source node, entry 0 unused since 11 takes ref_clk
    localparam int NET_SRC [9] = '{0, 0, 1, 0, 1, 2, 3, 6, 5};

    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
            cfg_o <= '0;    // mesh disabled
        else if (cfg_load_i)
            cfg_o <= cfg_i;
    end

    always_comb
    begin
        for (int i = 0; i < 9; i++)
        begin
            weights_o[i] = cfg_o.uni_dir ? UNI_W[i] : BI_W[i];
            if (cfg_o.network && i != 0)
                node_ref_o[i] = div8_i[NET_SRC[i]];
            else
                node_ref_o[i] = ref_clk_i;
        end
    end

endmodule

/* adpll_mesh_top.sv */
`timescale 1ns/1ps
`include "mesh_pll_params.svh"

module adpll_mesh_top (
    input  logic                    clk258_x,
    input  logic                    rst_n_i,
    input  logic                    cfg_load_i,
    input  mesh_pll_pkg::mesh_cfg_t cfg_i,
    output logic                    ref_clk_o,
    output logic [8:0]              gen_o,
    output logic [8:0]              div8_o
);
    import mesh_pll_pkg::*;

    mesh_cfg_t           cfg;
    node_weights_t [8:0] weights;
    logic [8:0]          node_ref;
    perr_t               err [9];
    nbr_err_t            nbr [9];

    // free-running reference, never corrected
    node_nco ref_nco (
        .clk258_x     (clk258_x),
        .rst_n_i      (rst_n_i),
        .enable_i     (1'b1),
        .center_inc_i (phase_t'(`MESH_REF_INC)),
        .ctrl_i       ('0),
        .clk_o        (ref_clk_o)
    );

    mesh_config cfg_inst (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n_i),
        .cfg_load_i (cfg_load_i),
        .cfg_i      (cfg_i),
        .ref_clk_i  (ref_clk_o),
        .div8_i     (div8_o),
        .cfg_o      (cfg),
        .weights_o  (weights),
        .node_ref_o (node_ref)
    );

    for (genvar i = 0; i < 9; i++)
    begin : g_node
        localparam int ROW = i / 3;
        localparam int COL = i % 3;

        // negated errors from right and lower neighbours, zero on the edge
        if (COL < 2)
        begin : g_right
            assign nbr[i].err_right = -err[i+1];
        end
        else
        begin : g_no_right
            assign nbr[i].err_right = '0;
        end

        if (ROW < 2)
        begin : g_below
            assign nbr[i].err_below = -err[i+3];
        end
        else
        begin : g_no_below
            assign nbr[i].err_below = '0;
        end

        adpll_node node_inst (
            .clk258_x     (clk258_x),
            .rst_n_i      (rst_n_i),
            .enable_i     (cfg.enable),
            .center_inc_i (node_center_inc[i]),
            .ref_i        (node_ref[i]),
            .nbr_i        (nbr[i]),
            .weights_i    (weights[i]),
            .kp_i         (cfg.kp),
            .ki_i         (cfg.ki),
            .err_o        (err[i]),
            .gen_o        (gen_o[i]),
            .div8_o       (div8_o[i])
        );
    end

endmodule

/* tb_adpll_mesh.sv */
`timescale 1ns/1ps
`include "mesh_pll_params.svh"

module tb_adpll_mesh;
    import mesh_pll_pkg::*;

    localparam int PHASE_STEPS = 1 << `MESH_PHASE_W;
    localparam int RATE_WINDOW = 4096;
    localparam int SETTLE_CYCLES = 20000;
    localparam int LOCK_WINDOW = 8192;
    localparam int TIMEOUT_CYCLES = 150000;     // tests need about 94k cycles

    // ring-length offsets in row-major order 11 .. 33
    localparam int RING_OFFSET [9] = '{0, 2, 18, 12, 10, -4, 0, 8, 0};

    logic       clk258_x;
    logic       rst_n_i;
    logic       cfg_load_i;
    mesh_cfg_t  cfg_i;
    logic       ref_clk_o;
    logic [8:0] gen_o;
    logic [8:0] div8_o;

    int errors = 0;
    int test_num = 1;
    int failed_tests = 0;
    int cycle_cnt = 0;
    int gen_cnt [9];
    int ref_cnt;

    adpll_mesh_top adpll_mesh_top_inst (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n_i),
        .cfg_load_i (cfg_load_i),
        .cfg_i      (cfg_i),
        .ref_clk_o  (ref_clk_o),
        .gen_o      (gen_o),
        .div8_o     (div8_o)
    );

    always #50 clk258_x = ~clk258_x;

    always @(posedge clk258_x)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("run stopped, no result after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic mesh_cfg_t make_cfg(input logic en, input logic net, input logic uni,
                                           input int kp, input int ki);
        mesh_cfg_t c;
        c.enable = en;
        c.network = net;
        c.uni_dir = uni;
        c.kp = gain_t'(kp);
        c.ki = gain_t'(ki);
        return c;
    endfunction

    // one-cycle strobe with the config live from the edge this task returns on
    task automatic load_cfg(input mesh_cfg_t c);
        @(posedge clk258_x);
        cfg_load_i <= 1'b1;
        cfg_i <= c;
        @(posedge clk258_x);
        cfg_load_i <= 1'b0;
    endtask

    task automatic count_edges(input int cycles);
        logic [8:0] gen_prev;
        logic       ref_prev;
        int         i;
        @(negedge clk258_x);
        gen_prev = gen_o;
        ref_prev = ref_clk_o;
        ref_cnt = 0;
        for (i = 0; i < 9; i++)
            gen_cnt[i] = 0;
        repeat (cycles)
        begin
            @(negedge clk258_x);    // outputs settled mid-cycle
            for (i = 0; i < 9; i++)
                if (gen_o[i] && !gen_prev[i])
                    gen_cnt[i]++;
            if (ref_clk_o && !ref_prev)
                ref_cnt++;
            gen_prev = gen_o;
            ref_prev = ref_clk_o;
        end
    endtask

    task automatic check_count(input string sig, input int got, input int exp, input int tol);
        assert (got >= exp - tol && got <= exp + tol)
        else
        begin
            $display("Error: %s rising edges 0x%0h, expected 0x%0h +/- 0x%0h",
                     sig, got, exp, tol);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before)
            $display("test %0d %s: ok", test_num, name);
        else
        begin
            $display("test %0d %s: FAILED", test_num, name);
            failed_tests++;
        end
        test_num++;
    endtask

    task automatic test_reset_idle();
        int         errs;
        logic [8:0] gen_seen;
        logic [8:0] div_seen;
        errs = errors;
        gen_seen = '0;
        div_seen = '0;
        repeat (500)
        begin
            @(negedge clk258_x);
            gen_seen |= gen_o;
            div_seen |= div8_o;
        end
        assert (gen_seen == '0)
        else
        begin
            $display("Error: gen_o 0x%03h, expected 0x000", gen_seen);
            errors++;
        end
        assert (div_seen == '0)
        else
        begin
            $display("Error: div8_o 0x%03h, expected 0x000", div_seen);
            errors++;
        end
        finish_test("idle after reset", errs);
    endtask

    task automatic test_ref_rate();
        int errs;
        errs = errors;
        count_edges(RATE_WINDOW);
        check_count("ref_clk_o", ref_cnt, `MESH_REF_INC * RATE_WINDOW / PHASE_STEPS, 1);
        finish_test("reference rate", errs);
    endtask

    task automatic test_free_run();
        int errs;
        int inc;
        int i;
        errs = errors;
        load_cfg(make_cfg(1'b1, 1'b0, 1'b1, 0, 0));     // no loop gain
        count_edges(RATE_WINDOW);
        for (i = 0; i < 9; i++)
        begin
            inc = `MESH_NODE_BASE_INC - `MESH_OFFSET_SCALE * RING_OFFSET[i];
            check_count($sformatf("gen_o[%0d]", i), gen_cnt[i],
                        inc * RATE_WINDOW / PHASE_STEPS, 1);
        end
        finish_test("free run", errs);
    endtask

    task automatic test_lock(input string name, input mesh_cfg_t c);
        int errs;
        int exp;
        int i;
        errs = errors;
        // eight gen edges per reference edge
        exp = 8 * `MESH_REF_INC * LOCK_WINDOW / PHASE_STEPS;
        load_cfg(c);
        repeat (SETTLE_CYCLES) @(posedge clk258_x);
        count_edges(LOCK_WINDOW);
        for (i = 0; i < 9; i++)
            check_count($sformatf("gen_o[%0d]", i), gen_cnt[i], exp, exp * 4 / 100);
        finish_test(name, errs);
    endtask

    task automatic test_shutdown();
        int errs;
        int waited;
        int i;
        errs = errors;
        load_cfg(make_cfg(1'b0, 1'b1, 1'b1, 4, 2));
        waited = 0;
        @(negedge clk258_x);
        while ((gen_o != '0 || div8_o != '0) && waited < 2)
        begin
            @(negedge clk258_x);
            waited++;
        end
        assert (gen_o == '0)
        else
        begin
            $display("Error: gen_o 0x%03h, expected 0x000", gen_o);
            errors++;
        end
        assert (div8_o == '0)
        else
        begin
            $display("Error: div8_o 0x%03h, expected 0x000", div8_o);
            errors++;
        end
        count_edges(200);   // must stay quiet
        for (i = 0; i < 9; i++)
            check_count($sformatf("gen_o[%0d]", i), gen_cnt[i], 0, 0);
        finish_test("disable", errs);
    endtask

    initial
    begin
        clk258_x = 1'b0;
        rst_n_i = 1'b0;
        cfg_load_i = 1'b0;
        cfg_i = '0;
        repeat (4) @(posedge clk258_x);
        rst_n_i <= 1'b1;

        test_reset_idle();
        test_ref_rate();
        test_free_run();
        test_lock("pll lock", make_cfg(1'b1, 1'b0, 1'b1, 4, 2));
        test_lock("network bidir lock", make_cfg(1'b1, 1'b1, 1'b0, 4, 2));
        test_lock("network unidir lock", make_cfg(1'b1, 1'b1, 1'b1, 4, 2));
        test_shutdown();

        $display("%0d tests, %0d failed, %0d check errors", test_num - 1, failed_tests, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
mesh_pll_pkg.sv
node_nco.sv
bb_phase_detector.sv
loop_filter.sv
adpll_node.sv
mesh_config.sv
adpll_mesh_top.sv
tb_adpll_mesh.sv

/* Makefile */
TOP = tb_adpll_mesh

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
